// File: bench/host_tasks.svh
`ifndef HOST_TASKS_SVH
`define HOST_TASKS_SVH

// poll ack once per clock until it reaches level
task automatic wait_ack(input logic level);
   int waited;
   waited = 0;
   while (up_ack !== level) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > ACK_WAIT_LIMIT)
         end_with_error($sformatf("host handshake hung, ack never went to %0b", level));
   end
endtask

function automatic bus_pkg::cmd_t make_cmd(input logic read, input logic kind,
                                           input logic [1:0] chan, input logic [1:0] reg_idx);
   bus_pkg::cmd_t cmd;
   cmd         = '0;
   cmd.read    = read;
   cmd.kind    = kind;
   cmd.chan    = chan;
   cmd.reg_idx = reg_idx;
   return cmd;
endfunction

// host drives the byte and the fpga samples it with ack
task automatic put_byte(input logic [7:0] value);
   @(posedge clk);
   #1;
   host_data = value;
   host_oe   = 1'b1;
   host_hs_1 = 1'b1;
   wait_ack(1'b1);
   host_hs_1 = 1'b0;
   wait_ack(1'b0);
endtask

// fpga drives the byte while ack is high
task automatic get_byte(output logic [7:0] value);
   @(posedge clk);
   #1;
   host_hs_1 = 1'b1;
   wait_ack(1'b1);
   if (up_handshake_2 !== 1'b1)
      end_with_error("DUT did not signal that it drives up_data during a read byte");
   value     = up_data;
   host_hs_1 = 1'b0;
   wait_ack(1'b0);
endtask

task automatic end_transaction();
   @(posedge clk);
   #1;
   host_start = 1'b0;
   host_rw    = 1'b0;
   host_oe    = 1'b0;
   repeat (IDLE_GAP) @(posedge clk);
   #1;
endtask

task automatic host_write(input logic kind, input logic [1:0] chan,
                          input logic [1:0] reg_idx, input logic [15:0] value);
   host_start = 1'b1;
   host_rw    = 1'b0;
   put_byte(make_cmd(1'b0, kind, chan, reg_idx));
   put_byte(value[15:8]);
   put_byte(value[7:0]);
   end_transaction();
endtask

task automatic host_read(input logic kind, input logic [1:0] chan,
                         input logic [1:0] reg_idx, output logic [15:0] value);
   logic [7:0] hi;
   logic [7:0] lo;
   host_start = 1'b1;
   host_rw    = 1'b0;
   put_byte(make_cmd(1'b1, kind, chan, reg_idx));
   @(posedge clk);
   #1;
   // release the bus before turning it around
   host_oe = 1'b0;
   host_rw = 1'b1;
   get_byte(hi);
   get_byte(lo);
   value = {hi, lo};
   end_transaction();
endtask

// ab phases in order with a leading b
function automatic logic [1:0] phase_ab(input logic [1:0] phase);
   case (phase)
      2'd0:    return 2'b00;
      2'd1:    return 2'b10;
      2'd2:    return 2'b11;
      default: return 2'b01;
   endcase
endfunction

task automatic qe_steps(input int chan, input int steps, input logic down);
   logic [1:0] ab;
   for (int n = 0; n < steps; n++) begin
      @(posedge clk);
      #1;
      qe_phase[chan] = down ? qe_phase[chan] - 2'd1 : qe_phase[chan] + 2'd1;
      ab             = phase_ab(qe_phase[chan]);
      quad[chan].a   = ab[1];
      quad[chan].b   = ab[0];
      repeat (STEP_GAP) @(posedge clk);
      #1;
   end
endtask

task automatic index_pulse(input int chan);
   @(posedge clk);
   #1;
   quad[chan].i = 1'b1;
   repeat (INDEX_WIDTH) @(posedge clk);
   #1;
   quad[chan].i = 1'b0;
   repeat (INDEX_WIDTH) @(posedge clk);
   #1;
endtask

`endif

// File: bench/motion_system_tb.sv
`timescale 1ns/10ps

module motion_system_tb;

   localparam int ACK_WAIT_LIMIT = 20;
   localparam int IDLE_GAP       = 6;
   localparam int STEP_GAP       = 5;
   localparam int INDEX_WIDTH    = 5;
   localparam int PWM_PERIOD     = 2 ** motion_pkg::PWM_BITS;
   localparam int SETTLE         = PWM_PERIOD + 4;
   localparam int DEAD_WINDOW    = PWM_PERIOD + 44;
   localparam int HOST_CYCLES    = 60;
   localparam int MAX_FWD_STEPS  = 60;
   localparam int MAX_REV_STEPS  = 120;
   localparam int NUM_ROWS       = 28;

   typedef enum logic [3:0] {
      OP_WR, OP_RD, OP_PWM, OP_DEAD, OP_STEP_RAND, OP_STEP, OP_INDEX, OP_RD_POS
   } op_t;

   typedef struct packed {
      op_t         op;
      logic        kind;
      logic [1:0]  chan;
      logic [1:0]  reg_idx;
      logic [15:0] data;
      logic [15:0] expected;
   } row_t;

   logic               clk;
   logic               arst_n;
   logic               host_start;
   logic               host_hs_1;
   logic               host_rw;
   logic [7:0]         host_data;
   logic               host_oe;
   logic               up_ack;
   logic               up_handshake_2;
   logic [1:0]         pwm_out;
   logic [1:0]         h_bridge_1;
   logic [1:0]         h_bridge_2;
   wire  [7:0]         up_data;
   motion_pkg::qe_in_t quad [motion_pkg::NOS_QE_CHANNELS];
   logic [1:0]         qe_phase [motion_pkg::NOS_QE_CHANNELS];
   logic [15:0]        pos_model [motion_pkg::NOS_QE_CHANNELS];
   int                 cycle_count;
   int                 cycle_limit;

   // data bit 0 selects reverse for pwm and random step rows
   // fixed step rows carry down in bit 15 and the step count in bits 7:0
   row_t rows [NUM_ROWS] = '{
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd0, bus_pkg::REG_PWM_CTRL, 16'h3f5a, 16'h0000},
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd1, bus_pkg::REG_PWM_CTRL, 16'h7e01, 16'h0000},
      '{OP_RD,   bus_pkg::KIND_PWM, 2'd0, bus_pkg::REG_PWM_CTRL, 16'h0000, 16'h3f5a},
      '{OP_RD,   bus_pkg::KIND_PWM, 2'd1, bus_pkg::REG_PWM_CTRL, 16'h0000, 16'h7e01},
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd0, bus_pkg::REG_PWM_CTRL, 16'h8040, 16'h0000},
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd1, bus_pkg::REG_PWM_CTRL, 16'h00c8, 16'h0000},
      '{OP_PWM,  bus_pkg::KIND_PWM, 2'd0, 2'd0, 16'h0000, 16'd64},
      '{OP_PWM,  bus_pkg::KIND_PWM, 2'd1, 2'd0, 16'h0000, 16'd0},
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd0, bus_pkg::REG_PWM_CTRL, 16'hc064, 16'h0000},
      '{OP_DEAD, bus_pkg::KIND_PWM, 2'd0, 2'd0, 16'h0000, 16'(motion_pkg::DEAD_CYCLES)},
      '{OP_PWM,  bus_pkg::KIND_PWM, 2'd0, 2'd0, 16'h0001, 16'd100},
      '{OP_WR,   bus_pkg::KIND_PWM, 2'd1, bus_pkg::REG_PWM_CTRL, 16'h80ff, 16'h0000},
      '{OP_PWM,  bus_pkg::KIND_PWM, 2'd1, 2'd0, 16'h0000, 16'd255},
      '{OP_RD,   bus_pkg::KIND_PWM, 2'd0, bus_pkg::REG_PWM_CTRL, 16'h0000, 16'hc064},
      '{OP_STEP_RAND, bus_pkg::KIND_QE, 2'd0, 2'd0, 16'h0000, 16'h0000},
      '{OP_STEP_RAND, bus_pkg::KIND_QE, 2'd0, 2'd0, 16'h0001, 16'h0000},
      '{OP_RD_POS, bus_pkg::KIND_QE, 2'd0, bus_pkg::REG_QE_COUNT, 16'h0000, 16'h0000},
      '{OP_WR,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_CTRL,  16'h4000, 16'h0000},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_CTRL,  16'h0000, 16'h4000},
      '{OP_STEP, bus_pkg::KIND_QE, 2'd1, 2'd0, 16'h000d, 16'h0000},
      '{OP_INDEX, bus_pkg::KIND_QE, 2'd1, 2'd0, 16'h0000, 16'h0000},
      '{OP_STEP, bus_pkg::KIND_QE, 2'd1, 2'd0, 16'h8005, 16'h0000},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_INDEX, 16'h0000, 16'h000d},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_COUNT, 16'h0000, 16'h0008},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_CTRL,  16'h0000, 16'h0000},
      '{OP_WR,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_CTRL,  16'h8000, 16'h0000},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_COUNT, 16'h0000, 16'h0000},
      '{OP_RD,   bus_pkg::KIND_QE, 2'd1, bus_pkg::REG_QE_INDEX, 16'h0000, 16'h000d}
   };

   assign up_data = host_oe ? host_data : 'z;

   motion_system i_dut (
      .clock_50(clk), .arst_n(arst_n),
      .async_up_start(host_start), .async_up_handshake_1(host_hs_1),
      .async_up_rw(host_rw), .quadrature(quad),
      .up_ack(up_ack), .up_handshake_2(up_handshake_2),
      .pwm_out(pwm_out), .h_bridge_1(h_bridge_1), .h_bridge_2(h_bridge_2),
      .up_data(up_data)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic end_with_error(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [15:0] actual,
                              input logic [15:0] expected);
      if (actual !== expected)
         end_with_error($sformatf("FAILED at %0t: %s, got 0x%h, expected 0x%h",
                                  $time, what, actual, expected));
   endtask

   `include "host_tasks.svh"

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit)
         end_with_error($sformatf("run did not finish within %0d clock cycles", cycle_limit));
   end

   function automatic int row_cycles(input row_t row);
      case (row.op)
         OP_PWM:       return SETTLE + PWM_PERIOD;
         OP_DEAD:      return DEAD_WINDOW;
         OP_STEP_RAND: return MAX_REV_STEPS * (STEP_GAP + 1);
         OP_STEP:      return int'(row.data[7:0]) * (STEP_GAP + 1);
         OP_INDEX:     return 2 * INDEX_WIDTH + 2;
         default:      return HOST_CYCLES;
      endcase
   endfunction

   // one period of a settled channel
   task automatic measure_period(input int chan, output int pwm_hi, output int h1_hi,
                                 output int h2_hi);
      pwm_hi = 0;
      h1_hi  = 0;
      h2_hi  = 0;
      repeat (SETTLE) @(posedge clk);
      repeat (PWM_PERIOD) begin
         @(posedge clk);
         #1;
         pwm_hi += pwm_out[chan];
         h1_hi  += h_bridge_1[chan];
         h2_hi  += h_bridge_2[chan];
      end
   endtask

   // pwm high while both legs are held off marks the dead time
   task automatic measure_dead(input int chan, output int dead, output int both);
      dead = 0;
      both = 0;
      repeat (DEAD_WINDOW) begin
         @(posedge clk);
         #1;
         if (pwm_out[chan] && !h_bridge_1[chan] && !h_bridge_2[chan])
            dead++;
         if (h_bridge_1[chan] && h_bridge_2[chan])
            both++;
      end
   endtask

   task automatic apply_row(input row_t row, input int r);
      logic [15:0] value;
      int          pwm_hi;
      int          h1_hi;
      int          h2_hi;
      int          dead;
      int          both;
      int          steps;
      case (row.op)
         OP_WR: host_write(row.kind, row.chan, row.reg_idx, row.data);
         OP_RD: begin
            host_read(row.kind, row.chan, row.reg_idx, value);
            check_value($sformatf("row %0d register read", r), value, row.expected);
         end
         OP_PWM: begin
            measure_period(row.chan, pwm_hi, h1_hi, h2_hi);
            check_value($sformatf("row %0d pwm_out high clocks", r), pwm_hi, row.expected);
            check_value($sformatf("row %0d h_bridge_1 high clocks", r), h1_hi,
                        row.data[0] ? 16'd0 : row.expected);
            check_value($sformatf("row %0d h_bridge_2 high clocks", r), h2_hi,
                        row.data[0] ? row.expected : 16'd0);
         end
         OP_DEAD: begin
            measure_dead(row.chan, dead, both);
            check_value($sformatf("row %0d dead time long enough", r),
                        16'(dead >= int'(row.expected)), 16'd1);
            check_value($sformatf("row %0d clocks with both legs on", r), both, 16'd0);
         end
         OP_STEP_RAND: begin
            steps = row.data[0] ? $urandom_range(MAX_REV_STEPS, 70)
                                : $urandom_range(MAX_FWD_STEPS, 20);
            qe_steps(row.chan, steps, row.data[0]);
            pos_model[row.chan] = row.data[0] ? pos_model[row.chan] - 16'(steps)
                                              : pos_model[row.chan] + 16'(steps);
         end
         OP_STEP:  qe_steps(row.chan, row.data[7:0], row.data[15]);
         OP_INDEX: index_pulse(row.chan);
         default: begin
            host_read(row.kind, row.chan, row.reg_idx, value);
            check_value($sformatf("row %0d position count", r), value, pos_model[row.chan]);
         end
      endcase
   endtask

   initial begin
      int total;
      void'($urandom(32574));
      total = 10;
      foreach (rows[r])
         total += row_cycles(rows[r]);
      cycle_limit = 2 * total;
      cycle_count = 0;
      arst_n      = 1'b0;
      host_start  = 1'b0;
      host_hs_1   = 1'b0;
      host_rw     = 1'b0;
      host_data   = '0;
      host_oe     = 1'b0;
      foreach (quad[c]) begin
         quad[c]      = '0;
         qe_phase[c]  = '0;
         pos_model[c] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      foreach (rows[r])
         apply_row(rows[r], r);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: files.f
+incdir+bench
source/bus_pkg.sv
source/motion_pkg.sv
source/up_port.sv
source/qe_channel.sv
source/pwm_channel.sv
source/bridge_driver.sv
source/motion_system.sv
bench/motion_system_tb.sv

// File: source/bridge_driver.sv
`timescale 1ns/10ps

module bridge_driver (
   input  logic               clk,
   input  logic               arst_n,
   input  motion_pkg::drive_t drive,
   output logic               pwm_out,
   output logic               h_bridge_1,
   output logic               h_bridge_2
);

   logic                             dir_q;
   logic [motion_pkg::DEAD_BITS-1:0] dead_cnt;
   logic                             legs_off;

   // both legs off on a direction change and while dead time runs
   assign legs_off = (drive.reverse != dir_q) || (dead_cnt != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dir_q    <= 1'b0;
         dead_cnt <= '0;
      end else if (drive.reverse != dir_q) begin
         dir_q    <= drive.reverse;
         dead_cnt <= motion_pkg::DEAD_BITS'(motion_pkg::DEAD_CYCLES - 1);
      end else if (dead_cnt != '0) begin
         dead_cnt <= dead_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pwm_out    <= 1'b0;
         h_bridge_1 <= 1'b0;
         h_bridge_2 <= 1'b0;
      end else begin
         pwm_out    <= drive.pwm;
         h_bridge_1 <= drive.pwm && !legs_off && !dir_q;
         h_bridge_2 <= drive.pwm && !legs_off && dir_q;
      end
   end

endmodule

// File: source/bus_pkg.sv
package bus_pkg;

   // bytes following the command byte
   localparam int DATA_BYTES = 2;

   localparam logic KIND_QE  = 1'b0;
   localparam logic KIND_PWM = 1'b1;

   // register index per channel kind
   localparam logic [1:0] REG_QE_COUNT = 2'd0;
   localparam logic [1:0] REG_QE_INDEX = 2'd1;
   localparam logic [1:0] REG_QE_CTRL  = 2'd2;
   localparam logic [1:0] REG_PWM_CTRL = 2'd0;

   typedef struct packed {
      logic       read;
      logic       kind;
      logic [1:0] chan;
      logic [1:0] unused;
      logic [1:0] reg_idx;
   } cmd_t;

   typedef struct packed {
      logic       enable;
      logic       reverse;
      logic [5:0] reserved;
      logic [7:0] duty;
   } pwm_ctrl_t;

   typedef struct packed {
      logic        clear;
      logic        index_arm;
      logic [13:0] reserved;
   } qe_ctrl_t;

   // same 16 bits decoded per channel kind
   typedef union packed {
      logic [15:0] raw;
      pwm_ctrl_t   pwm;
      qe_ctrl_t    qe;
   } reg_word_u;

   typedef struct packed {
      logic      strobe;
      logic      write;
      cmd_t      cmd;
      reg_word_u wdata;
   } bus_req_t;

   typedef struct packed {
      logic [15:0] rdata;
   } bus_rsp_t;

endpackage

// File: source/motion_pkg.sv
package motion_pkg;

   localparam int NOS_QE_CHANNELS  = 2;
   localparam int NOS_PWM_CHANNELS = 2;

   // response slots with the encoders before pwm
   localparam int NOS_SLOTS = NOS_QE_CHANNELS + NOS_PWM_CHANNELS;

   localparam int COUNT_BITS = 16;

   // 256 clock pwm period
   localparam int PWM_BITS = 8;

   localparam int DEAD_CYCLES = 4;
   localparam int DEAD_BITS   = $clog2(DEAD_CYCLES + 1);

   // pin group of one encoder
   typedef struct packed {
      logic a;
      logic b;
      logic i;
   } qe_in_t;

   // pwm channel to bridge driver
   typedef struct packed {
      logic pwm;
      logic reverse;
   } drive_t;

endpackage

// File: source/motion_system.sv
`timescale 1ns/10ps

module motion_system (
   input  logic                                   clock_50,
   input  logic                                   arst_n,
   input  logic                                   async_up_start,
   input  logic                                   async_up_handshake_1,
   input  logic                                   async_up_rw,
   input  motion_pkg::qe_in_t                     quadrature [motion_pkg::NOS_QE_CHANNELS],
   output logic                                   up_ack,
   output logic                                   up_handshake_2,
   output logic [motion_pkg::NOS_PWM_CHANNELS-1:0] pwm_out,
   output logic [motion_pkg::NOS_PWM_CHANNELS-1:0] h_bridge_1,
   output logic [motion_pkg::NOS_PWM_CHANNELS-1:0] h_bridge_2,
   inout  wire  [7:0]                             up_data
);

   bus_pkg::bus_req_t  req;
   bus_pkg::bus_rsp_t  rsp [motion_pkg::NOS_SLOTS];
   motion_pkg::drive_t drive [motion_pkg::NOS_PWM_CHANNELS];

   up_port i_up_port (
      .clk(clock_50), .arst_n(arst_n),
      .async_up_start(async_up_start), .async_up_handshake_1(async_up_handshake_1),
      .async_up_rw(async_up_rw), .rsp(rsp),
      .up_ack(up_ack), .up_handshake_2(up_handshake_2),
      .req(req), .up_data(up_data)
   );

   // input side and counters
   qe_channel #(.CHAN(2'd0)) i_qe_ch0 (
      .clk(clock_50), .arst_n(arst_n), .qe_in(quadrature[0]), .req(req), .rsp(rsp[0])
   );
   qe_channel #(.CHAN(2'd1)) i_qe_ch1 (
      .clk(clock_50), .arst_n(arst_n), .qe_in(quadrature[1]), .req(req), .rsp(rsp[1])
   );

   // pwm slots follow the encoder slots
   pwm_channel #(.CHAN(2'd0)) i_pwm_ch0 (
      .clk(clock_50), .arst_n(arst_n), .req(req),
      .rsp(rsp[motion_pkg::NOS_QE_CHANNELS]), .drive(drive[0])
   );
   pwm_channel #(.CHAN(2'd1)) i_pwm_ch1 (
      .clk(clock_50), .arst_n(arst_n), .req(req),
      .rsp(rsp[motion_pkg::NOS_QE_CHANNELS + 1]), .drive(drive[1])
   );

   bridge_driver i_bridge0 (
      .clk(clock_50), .arst_n(arst_n), .drive(drive[0]),
      .pwm_out(pwm_out[0]), .h_bridge_1(h_bridge_1[0]), .h_bridge_2(h_bridge_2[0])
   );
   bridge_driver i_bridge1 (
      .clk(clock_50), .arst_n(arst_n), .drive(drive[1]),
      .pwm_out(pwm_out[1]), .h_bridge_1(h_bridge_1[1]), .h_bridge_2(h_bridge_2[1])
   );

endmodule

// File: source/pwm_channel.sv
`timescale 1ns/10ps

module pwm_channel #(
   parameter logic [1:0] CHAN = 2'd0
) (
   input  logic               clk,
   input  logic               arst_n,
   input  bus_pkg::bus_req_t  req,
   output bus_pkg::bus_rsp_t  rsp,
   output motion_pkg::drive_t drive
);

   logic [motion_pkg::PWM_BITS-1:0] counter;
   logic                            sel;
   logic                            wrap;
   bus_pkg::reg_word_u              ctrl_q;
   bus_pkg::pwm_ctrl_t              active;

   assign sel  = req.strobe && req.cmd.kind == bus_pkg::KIND_PWM && req.cmd.chan == CHAN;
   assign wrap = (counter == '1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         counter <= '0;
      else
         counter <= counter + 1'b1;
   end

   // host copy keeps the reserved bits for read back
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         ctrl_q <= '0;
      else if (sel && req.write && req.cmd.reg_idx == bus_pkg::REG_PWM_CTRL)
         ctrl_q <= req.wdata;
   end

   // new settings only at period boundary
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         active <= '0;
      else if (wrap)
         active <= ctrl_q.pwm;
   end

   always_ff @(posedge clk) begin
      if (sel && !req.write) begin
         if (req.cmd.reg_idx == bus_pkg::REG_PWM_CTRL)
            rsp.rdata <= ctrl_q.raw;
         else
            rsp.rdata <= '0;
      end
   end

   assign drive.pwm     = active.enable && (counter < active.duty);
   assign drive.reverse = active.reverse;

endmodule

// File: source/qe_channel.sv
`timescale 1ns/10ps

module qe_channel #(
   parameter logic [1:0] CHAN = 2'd0
) (
   input  logic               clk,
   input  logic               arst_n,
   input  motion_pkg::qe_in_t qe_in,
   input  bus_pkg::bus_req_t  req,
   output bus_pkg::bus_rsp_t  rsp
);

   motion_pkg::qe_in_t                meta;
   motion_pkg::qe_in_t                sync;
   motion_pkg::qe_in_t                prev;
   logic                              sel;
   logic                              ctrl_wr;
   logic                              step;
   logic                              up;
   logic                              index_rise;
   logic                              armed;
   logic [motion_pkg::COUNT_BITS-1:0] count;
   logic [motion_pkg::COUNT_BITS-1:0] index_q;
   bus_pkg::qe_ctrl_t                 ctrl_rd;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         meta <= '0;
         sync <= '0;
         prev <= '0;
      end else begin
         meta <= qe_in;
         sync <= meta;
         prev <= sync;
      end
   end

   // a valid gray step changes exactly one of a and b
   assign step       = (sync.a ^ prev.a) ^ (sync.b ^ prev.b);
   // a leading b counts up
   assign up         = !(prev.a ^ sync.b);
   assign index_rise = sync.i && !prev.i;

   assign sel     = req.strobe && req.cmd.kind == bus_pkg::KIND_QE && req.cmd.chan == CHAN;
   assign ctrl_wr = sel && req.write && req.cmd.reg_idx == bus_pkg::REG_QE_CTRL;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         count <= '0;
      else if (ctrl_wr && req.wdata.qe.clear)
         count <= '0;
      else if (step)
         count <= up ? count + 1'b1 : count - 1'b1;
   end

   // one shot latch that the host rearms
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         armed   <= 1'b0;
         index_q <= '0;
      end else begin
         if (armed && index_rise) begin
            index_q <= count;
            armed   <= 1'b0;
         end
         if (ctrl_wr && req.wdata.qe.index_arm)
            armed <= 1'b1;
      end
   end

   always_comb begin
      ctrl_rd           = '0;
      ctrl_rd.index_arm = armed;
   end

   always_ff @(posedge clk) begin
      if (sel && !req.write) begin
         case (req.cmd.reg_idx)
            bus_pkg::REG_QE_COUNT: rsp.rdata <= count;
            bus_pkg::REG_QE_INDEX: rsp.rdata <= index_q;
            bus_pkg::REG_QE_CTRL:  rsp.rdata <= ctrl_rd;
            default:               rsp.rdata <= '0;
         endcase
      end
   end

endmodule

// File: source/up_port.sv
`timescale 1ns/10ps

module up_port (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               async_up_start,
   input  logic               async_up_handshake_1,
   input  logic               async_up_rw,
   input  bus_pkg::bus_rsp_t  rsp [motion_pkg::NOS_SLOTS],
   output logic               up_ack,
   output logic               up_handshake_2,
   output bus_pkg::bus_req_t  req,
   inout  wire  [7:0]         up_data
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT_HI,
      S_WAIT_LO,
      S_END
   } state_t;

   state_t             state;
   logic [2:0]         meta;
   logic [2:0]         sync;
   logic               start_s;
   logic               hs_s;
   logic               rw_s;
   logic [1:0]         byte_cnt;
   logic               last_byte;
   logic               issue;
   logic               strobe;
   bus_pkg::cmd_t      cmd_in;
   bus_pkg::cmd_t      cmd_q;
   bus_pkg::reg_word_u wr_word;
   logic [15:0]        rd_word;
   logic [7:0]         rd_byte;
   logic               drive_en;

   // two flop synchronizers for start, handshake_1 and rw
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         meta <= '0;
         sync <= '0;
      end else begin
         meta <= {async_up_start, async_up_handshake_1, async_up_rw};
         sync <= meta;
      end
   end

   assign start_s = sync[2];
   assign hs_s    = sync[1];
   assign rw_s    = sync[0];

   assign cmd_in    = up_data;
   assign last_byte = (byte_cnt == 2'(bus_pkg::DATA_BYTES));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         byte_cnt <= '0;
         up_ack   <= 1'b0;
         issue    <= 1'b0;
         strobe   <= 1'b0;
         cmd_q    <= '0;
      end else begin
         // strobe lands one cycle after the ack that requested it
         strobe <= issue;
         issue  <= 1'b0;
         case (state)
            S_IDLE: begin
               byte_cnt <= '0;
               if (start_s)
                  state <= S_WAIT_HI;
            end
            S_WAIT_HI: begin
               if (!start_s) begin
                  state <= S_IDLE;
               end else if (hs_s) begin
                  up_ack <= 1'b1;
                  state  <= S_WAIT_LO;
                  if (byte_cnt == '0) begin
                     cmd_q <= cmd_in;
                     // read is fetched before the first data byte
                     issue <= cmd_in.read;
                  end else begin
                     issue <= last_byte && !cmd_q.read;
                  end
               end
            end
            S_WAIT_LO: begin
               if (!start_s) begin
                  up_ack <= 1'b0;
                  state  <= S_IDLE;
               end else if (!hs_s) begin
                  up_ack <= 1'b0;
                  if (last_byte) begin
                     state <= S_END;
                  end else begin
                     byte_cnt <= byte_cnt + 2'd1;
                     state    <= S_WAIT_HI;
                  end
               end
            end
            S_END: begin
               if (!start_s)
                  state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // high byte first
   always_ff @(posedge clk) begin
      if (state == S_WAIT_HI && start_s && hs_s && byte_cnt != '0 && !cmd_q.read)
         wr_word.raw <= {wr_word.raw[7:0], up_data};
   end

   // response of the addressed channel
   always_comb begin
      rd_word = '0;
      if (cmd_q.kind == bus_pkg::KIND_QE && cmd_q.chan < motion_pkg::NOS_QE_CHANNELS)
         rd_word = rsp[cmd_q.chan].rdata;
      else if (cmd_q.kind == bus_pkg::KIND_PWM && cmd_q.chan < motion_pkg::NOS_PWM_CHANNELS)
         rd_word = rsp[motion_pkg::NOS_QE_CHANNELS + cmd_q.chan].rdata;
   end

   assign rd_byte = (byte_cnt == 2'd1) ? rd_word[15:8] : rd_word[7:0];

   // host has released the bus once rw is high
   assign drive_en = cmd_q.read && rw_s && byte_cnt != '0 &&
                     (state == S_WAIT_HI || state == S_WAIT_LO);

   assign up_data        = drive_en ? rd_byte : 'z;
   assign up_handshake_2 = drive_en;

   assign req = '{strobe: strobe, write: !cmd_q.read, cmd: cmd_q, wdata: wr_word};

endmodule
